/* realign_cfg.svh */
// Re-aligner configuration
`ifndef REALIGN_CFG_SVH
`define REALIGN_CFG_SVH

// ------------------------------------------------
// address and fetch geometry
// ------------------------------------------------

// virtual address width of the fetch front end
`define REALIGN_VLEN 32

// width of one fetch word in bits
// the re-aligner is built for a 32-bit fetch only
`define REALIGN_FETCH_WIDTH 32

// instructions that can leave the re-aligner per fetch
// two compressed parcels are the most a 32-bit word can hold
`define REALIGN_SLOTS 2

`endif

/* isa_pkg.sv */
// RISC-V instruction encoding
`include "realign_cfg.svh"

package isa_pkg;

    // one instruction parcel is a halfword
    localparam int unsigned PARCEL_W = 16;

    // a full-width instruction has both low bits of its first parcel set
    localparam logic [1:0] FULL_LEN_MARK = 2'b11;

    typedef logic [PARCEL_W-1:0] parcel_t;

    // a compressed instruction sits zero-extended in the low half
    typedef logic [2*PARCEL_W-1:0] instr_t;

    // any other pattern in the low bits marks a compressed parcel
    function automatic logic is_compressed(parcel_t parcel);
        return parcel[1:0] != FULL_LEN_MARK;
    endfunction

    function automatic instr_t zext_parcel(parcel_t parcel);
        return instr_t'(parcel);
    endfunction

    // the lower parcel of a full instruction sits at the lower address
    function automatic instr_t join_parcels(parcel_t upper, parcel_t lower);
        return {upper, lower};
    endfunction

endpackage

/* fetch_pkg.sv */
// Fetch front-end types
`include "realign_cfg.svh"

package fetch_pkg;

    import isa_pkg::*;

    // ------------------------------------------------
    // fetch side
    // ------------------------------------------------

    // virtual address of a fetch or of a single instruction
    typedef logic [`REALIGN_VLEN-1:0] vaddr_t;

    // raw data of one fetch with the lowest parcel at the lowest address
    typedef logic [`REALIGN_FETCH_WIDTH-1:0] fetch_word_t;

    // number of parcels carried by one fetch word
    localparam int unsigned FETCH_PARCELS = `REALIGN_FETCH_WIDTH / PARCEL_W;

    // ------------------------------------------------
    // slot side
    // ------------------------------------------------

    // one valid strobe per output slot where slot 0 is the oldest instruction
    typedef logic [`REALIGN_SLOTS-1:0] slot_mask_t;

    // instruction word of each slot
    typedef instr_t [`REALIGN_SLOTS-1:0] slot_instr_t;

    // address of the first parcel of each slot
    typedef vaddr_t [`REALIGN_SLOTS-1:0] slot_addr_t;

    // slot indices used by the stages
    localparam int unsigned SLOT_FIRST  = 0;
    localparam int unsigned SLOT_SECOND = 1;

endpackage

/* realign_ifs.sv */
// Re-aligner stage interfaces
`include "realign_cfg.svh"

// decoded view of one fetch that runs from the decode stage to execute and result
interface parcel_if import isa_pkg::*, fetch_pkg::*;;

    logic    valid;
    parcel_t lo_parcel;
    parcel_t hi_parcel;
    logic    lo_rvc;
    logic    hi_rvc;
    // set only for a valid fetch that enters at the upper halfword
    logic    odd_entry;
    vaddr_t  word_addr;
    vaddr_t  hi_addr;

    modport decode_mp (
        output valid, lo_parcel, hi_parcel, lo_rvc, hi_rvc, odd_entry, word_addr, hi_addr
    );

    modport ctrl_mp (
        input valid, lo_rvc, hi_rvc, odd_entry, lo_parcel, hi_parcel, hi_addr
    );

    modport asm_mp (
        input lo_parcel, hi_parcel, word_addr, hi_addr
    );

endinterface

// slot decision and carried parcel that run from the execute stage to the result stage
interface slot_if import isa_pkg::*, fetch_pkg::*;;

    slot_mask_t slot_valid;
    // slot 0 is the held parcel joined with the low parcel
    logic       use_carry;
    parcel_t    carry_parcel;
    vaddr_t     carry_addr;
    vaddr_t     entry_addr;

    modport ctrl_mp (output slot_valid, use_carry, carry_parcel, carry_addr, entry_addr);

    modport asm_mp (input slot_valid, use_carry, carry_parcel, carry_addr, entry_addr);

endinterface

/* parcel_decode.sv */
// Fetch word parcel decode
`include "realign_cfg.svh"

module parcel_decode import isa_pkg::*, fetch_pkg::*; (
    input  logic        valid_i,
    input  vaddr_t      address_i,
    input  fetch_word_t data_i,
    parcel_if.decode_mp parcel_o
);

    // the fetch word viewed as an array of halfword parcels
    parcel_t [FETCH_PARCELS-1:0] parcels;
    logic    [FETCH_PARCELS-1:0] rvc;
    vaddr_t                      word_addr;

    assign parcels = data_i;

    // ------------------------------------------------
    // parcel classification
    // ------------------------------------------------

    // every parcel is tested and the execute stage decides which flags count
    for (genvar i = 0; i < FETCH_PARCELS; i++) begin : gen_rvc
        assign rvc[i] = is_compressed(parcels[i]);
    end

    assign parcel_o.lo_parcel = parcels[0];
    assign parcel_o.hi_parcel = parcels[1];
    assign parcel_o.lo_rvc    = rvc[0];
    assign parcel_o.hi_rvc    = rvc[1];

    // ------------------------------------------------
    // entry point and addresses
    // ------------------------------------------------

    assign parcel_o.valid = valid_i;

    // an entry at the upper halfword only counts for a real fetch
    assign parcel_o.odd_entry = valid_i & address_i[1];

    // clearing bit 1 gives the address of the low parcel
    assign word_addr = {address_i[`REALIGN_VLEN-1:2], 1'b0, address_i[0]};

    assign parcel_o.word_addr = word_addr;

    // the high parcel always lives one halfword above
    assign parcel_o.hi_addr = word_addr + vaddr_t'(2);

endmodule

/* realign_ctrl.sv */
// Re-aligner carry control
`include "realign_cfg.svh"

module realign_ctrl import isa_pkg::*, fetch_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      clr_i,
    input  logic      flush_i,
    parcel_if.ctrl_mp parcel_i,
    slot_if.ctrl_mp   slot_o,
    output logic      serving_unaligned_o
);

    // the carry flag is set while the lower half of a full instruction is held
    logic    carry_d, carry_q;
    // held parcel and the address it was fetched from
    parcel_t held_parcel_d, held_parcel_q;
    vaddr_t  held_addr_d, held_addr_q;

    // ------------------------------------------------
    // slot and carry decision
    // ------------------------------------------------

    always_comb begin
        // by default the carry stays as it is
        carry_d       = carry_q;
        held_parcel_d = parcel_i.hi_parcel;
        held_addr_d   = parcel_i.hi_addr;

        // slot 0 always carries something on a plain valid fetch
        slot_o.slot_valid              = '0;
        slot_o.slot_valid[SLOT_FIRST]  = parcel_i.valid;
        slot_o.use_carry               = carry_q;

        // a held parcel or a compressed low parcel frees the upper half
        // so slot 1 depends only on the high parcel
        if (carry_q || parcel_i.lo_rvc) begin
            if (parcel_i.hi_rvc) begin
                slot_o.slot_valid[SLOT_SECOND] = parcel_i.valid;
                carry_d                        = 1'b0;
            end else begin
                // the upper half starts a full instruction that the next fetch completes
                carry_d = 1'b1;
            end
        end

        // an entry at the upper halfword wins over anything held
        // and makes the low parcel the first instruction of the fetch
        if (parcel_i.odd_entry) begin
            slot_o.use_carry = 1'b0;
            if (!parcel_i.lo_rvc) begin
                // nothing is complete yet and the next word supplies the upper half
                slot_o.slot_valid = '0;
                carry_d           = 1'b1;
                held_parcel_d     = parcel_i.lo_parcel;
            end else begin
                slot_o.slot_valid             = '0;
                slot_o.slot_valid[SLOT_FIRST] = 1'b1;
                carry_d                       = 1'b0;
            end
        end
    end

    // an odd entry sits one halfword above the word and any other entry at the word itself
    assign slot_o.entry_addr = parcel_i.odd_entry ? parcel_i.hi_addr
                                                  : parcel_i.hi_addr - vaddr_t'(2);

    assign slot_o.carry_parcel = held_parcel_q;
    assign slot_o.carry_addr   = held_addr_q;
    assign serving_unaligned_o = carry_q;

    // ------------------------------------------------
    // carry registers
    // ------------------------------------------------

    // flush drops the carry at the next edge whatever the fetch does
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            carry_q <= 1'b0;
        end else if (flush_i) begin
            carry_q <= 1'b0;
        end else if (parcel_i.valid) begin
            carry_q <= carry_d;
        end
    end

    // the held halfword and its address are read only while the flag is set
    always_ff @(posedge clk_i) begin
        if (clr_i) begin
            held_parcel_q <= '0;
            held_addr_q   <= '0;
        end else if (parcel_i.valid) begin
            held_parcel_q <= held_parcel_d;
            held_addr_q   <= held_addr_d;
        end
    end

endmodule

/* slot_assemble.sv */
// Output slot assembly
`include "realign_cfg.svh"

module slot_assemble import isa_pkg::*, fetch_pkg::*; (
    parcel_if.asm_mp    parcel_i,
    slot_if.asm_mp      slot_i,
    output slot_mask_t  valid_o,
    output slot_instr_t instr_o,
    output slot_addr_t  addr_o
);

    // instruction of each slot before the invalid slots are blanked
    slot_instr_t slot_instr;
    // the entry address differs from the word address only on an odd entry
    logic        odd_entry;

    assign odd_entry = slot_i.entry_addr != parcel_i.word_addr;

    // ------------------------------------------------
    // slot 0
    // ------------------------------------------------

    always_comb begin
        if (slot_i.use_carry) begin
            // held lower half below the low parcel of this fetch
            slot_instr[SLOT_FIRST] = join_parcels(parcel_i.lo_parcel, slot_i.carry_parcel);
            addr_o[SLOT_FIRST]     = slot_i.carry_addr;
        end else if (odd_entry) begin
            // a compressed parcel at the entry point
            slot_instr[SLOT_FIRST] = zext_parcel(parcel_i.lo_parcel);
            addr_o[SLOT_FIRST]     = slot_i.entry_addr;
        end else begin
            slot_instr[SLOT_FIRST] = join_parcels(parcel_i.hi_parcel, parcel_i.lo_parcel);
            addr_o[SLOT_FIRST]     = slot_i.entry_addr;
        end
    end

    // ------------------------------------------------
    // slot 1
    // ------------------------------------------------

    // only ever a compressed parcel from the upper half
    assign slot_instr[SLOT_SECOND] = zext_parcel(parcel_i.hi_parcel);
    assign addr_o[SLOT_SECOND]     = parcel_i.hi_addr;

    // ------------------------------------------------
    // output masking
    // ------------------------------------------------

    for (genvar i = 0; i < `REALIGN_SLOTS; i++) begin : gen_mask
        assign instr_o[i] = slot_i.slot_valid[i] ? slot_instr[i] : '0;
    end

    assign valid_o = slot_i.slot_valid;

endmodule

/* instr_realign.sv */
// Instruction re-aligner top
`include "realign_cfg.svh"

module instr_realign import fetch_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_ni,
    input  logic        clr_i,
    input  logic        flush_i,
    input  logic        valid_i,
    input  vaddr_t      address_i,
    input  fetch_word_t data_i,
    // the lower half of a full instruction is held from the last fetch
    output logic        serving_unaligned_o,
    output slot_mask_t  valid_o,
    output slot_addr_t  addr_o,
    output slot_instr_t instr_o
);

    // decoded fetch and slot decision between the stages
    parcel_if parcel_bus ();
    slot_if   slot_bus ();

    // split the fetch word and form the parcel addresses
    parcel_decode u_decode (
        .valid_i   (valid_i),
        .address_i (address_i),
        .data_i    (data_i),
        .parcel_o  (parcel_bus)
    );

    // carry state and slot validity
    realign_ctrl u_ctrl (
        .clk_i               (clk_i),
        .rst_ni              (rst_ni),
        .clr_i               (clr_i),
        .flush_i             (flush_i),
        .parcel_i            (parcel_bus),
        .slot_o              (slot_bus),
        .serving_unaligned_o (serving_unaligned_o)
    );

    // build instruction and address per slot
    slot_assemble u_assemble (
        .parcel_i (parcel_bus),
        .slot_i   (slot_bus),
        .valid_o  (valid_o),
        .instr_o  (instr_o),
        .addr_o   (addr_o)
    );

endmodule

/* tb_instr_realign.sv */
// Instruction re-aligner testbench
`include "realign_cfg.svh"

module tb_instr_realign import isa_pkg::*, fetch_pkg::*;;

    localparam int CLK_PERIOD   = 4;
    localparam int RAND_FETCHES = 400;
    // reset and directed fetches stay well under 60 cycles
    localparam int TIMEOUT      = (RAND_FETCHES + 60) * CLK_PERIOD + 200;

    logic        clk_i, rst_ni, clr_i, flush_i, valid_i;
    vaddr_t      address_i;
    fetch_word_t data_i;
    logic        serving_unaligned_o;
    slot_mask_t  valid_o;
    slot_addr_t  addr_o;
    slot_instr_t instr_o;

    // reference model state and the response it expects for the current fetch
    logic        m_carry;
    parcel_t     m_parcel;
    vaddr_t      m_addr;
    logic        exp_serving;
    slot_mask_t  exp_valid;
    slot_instr_t exp_instr;
    slot_addr_t  exp_addr;
    logic [31:0] lfsr_state  = 32'h36d;
    int          error_count = 0;

    instr_realign dut0 (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    initial begin
        #(TIMEOUT);
        $display("watchdog expired, the tests did not finish in the expected time");
        $display("Verification failed");
        $fatal(1, "timeout");
    end

    // --------------------------------------------------
    // random source and checker
    // --------------------------------------------------

    // fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // a compressed parcel never has both low bits set
    task automatic make_parcel(input logic compressed, output parcel_t p);
        logic [31:0] v;
        random_bits(16, v);
        if (!compressed) begin
            p = {v[15:2], 2'b11};
        end else begin
            p = {v[15:2], (v[1:0] == 2'b11) ? 2'b00 : v[1:0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Verification failed");
            $fatal(1, "output mismatch");
        end
    endtask

    // --------------------------------------------------
    // reference model
    // --------------------------------------------------

    task automatic predict(input logic valid, input vaddr_t addr, input fetch_word_t data,
                           input logic flush, input logic clr);
        parcel_t lo;
        parcel_t hi;
        vaddr_t  word;
        logic    nxt_carry;
        parcel_t nxt_parcel;
        vaddr_t  nxt_addr;
        lo          = data[15:0];
        hi          = data[31:16];
        word        = {addr[`REALIGN_VLEN-1:2], 2'b00};
        exp_serving = m_carry;
        exp_valid   = '0;
        exp_instr   = '0;
        exp_addr    = '0;
        nxt_carry   = m_carry;
        nxt_parcel  = m_parcel;
        nxt_addr    = m_addr;
        if (valid && addr[1]) begin
            // entry at the upper halfword overrides whatever is held
            if (lo[1:0] != 2'b11) begin
                exp_valid[0] = 1'b1;
                exp_instr[0] = {16'h0, lo};
                exp_addr[0]  = addr;
                nxt_carry    = 1'b0;
            end else begin
                nxt_carry  = 1'b1;
                nxt_parcel = lo;
                nxt_addr   = word + vaddr_t'(2);
            end
        end else if (valid) begin
            exp_valid[0] = 1'b1;
            exp_instr[0] = m_carry ? {lo, m_parcel} : data;
            exp_addr[0]  = m_carry ? m_addr : addr;
            // the upper halfword is free once the low one is consumed
            if (m_carry || lo[1:0] != 2'b11) begin
                if (hi[1:0] != 2'b11) begin
                    exp_valid[1] = 1'b1;
                    exp_instr[1] = {16'h0, hi};
                    exp_addr[1]  = word + vaddr_t'(2);
                    nxt_carry    = 1'b0;
                end else begin
                    nxt_carry  = 1'b1;
                    nxt_parcel = hi;
                    nxt_addr   = word + vaddr_t'(2);
                end
            end
        end
        // state as it will be after the coming edge
        m_carry  = nxt_carry && !flush;
        m_parcel = clr ? '0 : nxt_parcel;
        m_addr   = clr ? '0 : nxt_addr;
    endtask

    task automatic compare_outputs();
        check_value("serving_unaligned_o", 32'(serving_unaligned_o), 32'(exp_serving));
        check_value("valid_o", 32'(valid_o), 32'(exp_valid));
        for (int i = 0; i < `REALIGN_SLOTS; i++) begin
            check_value($sformatf("instr_o[%0d]", i), instr_o[i], exp_instr[i]);
            if (exp_valid[i]) begin
                check_value($sformatf("addr_o[%0d]", i), addr_o[i], exp_addr[i]);
            end
        end
    endtask

    // one fetch per cycle that is checked in the low phase where the outputs are stable
    task automatic drive_fetch(input logic valid, input vaddr_t addr, input fetch_word_t data,
                               input logic flush, input logic clr);
        @(posedge clk_i);
        valid_i   <= valid;
        address_i <= addr;
        data_i    <= data;
        flush_i   <= flush;
        clr_i     <= clr;
        predict(valid, addr, data, flush, clr);
        @(negedge clk_i);
        compare_outputs();
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------

    task automatic reset_idle_test();
        check_value("serving_unaligned_o", 32'(serving_unaligned_o), 32'd0);
        repeat (3) drive_fetch(1'b0, 32'h0000_0100, 32'hffff_ffff, 1'b0, 1'b0);
    endtask

    task automatic aligned_test();
        parcel_t lo;
        parcel_t hi;
        make_parcel(1'b0, lo);
        make_parcel(1'b1, hi);
        drive_fetch(1'b1, 32'h0000_1000, {hi, lo}, 1'b0, 1'b0);
        check_value("valid_o", 32'(valid_o), 32'd1);
        make_parcel(1'b1, lo);
        make_parcel(1'b1, hi);
        drive_fetch(1'b1, 32'h0000_1004, {hi, lo}, 1'b0, 1'b0);
        check_value("valid_o", 32'(valid_o), 32'd3);
    endtask

    task automatic carry_test();
        parcel_t lo;
        parcel_t hi;
        make_parcel(1'b1, lo);
        make_parcel(1'b0, hi);
        drive_fetch(1'b1, 32'h0000_1010, {hi, lo}, 1'b0, 1'b0);
        // the held half survives an idle cycle
        drive_fetch(1'b0, 32'h0000_1014, 32'h0, 1'b0, 1'b0);
        check_value("serving_unaligned_o", 32'(serving_unaligned_o), 32'd1);
        make_parcel(1'b0, lo);
        make_parcel(1'b1, hi);
        drive_fetch(1'b1, 32'h0000_1014, {hi, lo}, 1'b0, 1'b0);
        check_value("valid_o", 32'(valid_o), 32'd3);
    endtask

    task automatic odd_entry_test();
        parcel_t lo;
        parcel_t hi;
        make_parcel(1'b0, lo);
        make_parcel(1'b1, hi);
        drive_fetch(1'b1, 32'h0000_2002, {hi, lo}, 1'b0, 1'b0);
        check_value("valid_o", 32'(valid_o), 32'd0);
        make_parcel(1'b1, lo);
        make_parcel(1'b1, hi);
        drive_fetch(1'b1, 32'h0000_2004, {hi, lo}, 1'b0, 1'b0);
        check_value("serving_unaligned_o", 32'(serving_unaligned_o), 32'd1);
        make_parcel(1'b1, lo);
        make_parcel(1'b0, hi);
        drive_fetch(1'b1, 32'h0000_3006, {hi, lo}, 1'b0, 1'b0);
        check_value("valid_o", 32'(valid_o), 32'd1);
    endtask

    task automatic flush_test();
        parcel_t lo;
        parcel_t hi;
        make_parcel(1'b1, lo);
        make_parcel(1'b0, hi);
        drive_fetch(1'b1, 32'h0000_4000, {hi, lo}, 1'b0, 1'b0);
        drive_fetch(1'b0, 32'h0000_4004, 32'h0, 1'b1, 1'b0);
        make_parcel(1'b0, lo);
        drive_fetch(1'b1, 32'h0000_8000, {hi, lo}, 1'b0, 1'b0);
        check_value("serving_unaligned_o", 32'(serving_unaligned_o), 32'd0);
    endtask

    // sequential stream with idle cycles, jumps into upper halves, flushes and clears
    task automatic random_mix_test(input int n);
        logic [31:0] r;
        logic [31:0] j;
        parcel_t     lo;
        parcel_t     hi;
        vaddr_t      pc;
        logic        valid;
        logic        flush;
        logic        clr;
        pc = 32'h0001_0000;
        for (int k = 0; k < n; k++) begin
            random_bits(15, r);
            make_parcel(r[0], lo);
            make_parcel(r[1], hi);
            valid = (r[3:2] != 2'b00);
            flush = (r[10:7] == 4'b0000);
            clr   = (r[14:11] == 4'b0000);
            if (r[6:4] == 3'b000) begin
                random_bits(14, j);
                pc = {16'h0001, j[13:0], 2'b10};
            end
            drive_fetch(valid, pc, {hi, lo}, flush, clr);
            if (valid) begin
                pc = {pc[`REALIGN_VLEN-1:2], 2'b00} + vaddr_t'(4);
            end
        end
    endtask

    initial begin
        clk_i     = 1'b0;
        rst_ni    = 1'b0;
        clr_i     = 1'b1;
        flush_i   = 1'b0;
        valid_i   = 1'b0;
        address_i = '0;
        data_i    = '0;
        m_carry   = 1'b0;
        m_parcel  = '0;
        m_addr    = '0;
        repeat (2) @(posedge clk_i);
        rst_ni <= 1'b1;
        clr_i  <= 1'b0;
        reset_idle_test();
        aligned_test();
        carry_test();
        odd_entry_test();
        flush_test();
        random_mix_test(RAND_FETCHES);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+.
isa_pkg.sv
fetch_pkg.sv
realign_ifs.sv
parcel_decode.sv
realign_ctrl.sv
slot_assemble.sv
instr_realign.sv
tb_instr_realign.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -f src.f --top-module tb_instr_realign -Mdir obj_dir -o sim
	./obj_dir/sim | tee $(LOG)
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
